/* src/monitor_pkg.sv */
// Board monitor shared definitions
// Widths, status codes, display modes and the run-phase encoding
// used by the processor monitor blocks

package monitor_pkg;

	// ====================
	// Widths with a meaning
	// ====================
	typedef logic [31:0] count_t;          // Cycle or instruction count
	typedef logic [3:0]  nibble_t;         // One hex digit
	typedef logic [6:0]  segments_t;       // Segments g..a, active low
	typedef logic [1:0]  status_code_t;    // Status report kind
	typedef logic [15:0] status_value_t;   // Payload sent with a report
	typedef logic [21:0] fetch_addr_t;     // Processor fetch address
	typedef logic [1:0]  display_mode_t;   // Switch setting for the digits

	// ====================
	// Status report codes
	// ====================
	localparam status_code_t StatusNoop = 2'd0;   // No meaning, dropped
	localparam status_code_t StatusPass = 2'd1;   // Test passed
	localparam status_code_t StatusFail = 2'd2;   // Test failed
	localparam status_code_t StatusDone = 2'd3;   // Program finished

	// ====================
	// Display modes
	// ====================
	// Status view puts the glyph on digit 2
	localparam display_mode_t ModeStatus = 2'd0;
	localparam display_mode_t ModeCycles = 2'd1;  // Cycle counter
	localparam display_mode_t ModeInstrs = 2'd2;  // Retired instructions
	localparam display_mode_t ModeBlank  = 2'd3;  // All digits zero

	// ====================
	// Run phases
	// ====================
	// Loading until the image is in memory, then running until DONE
	typedef enum logic [1:0]
	{
		RunLoading = 2'd0,
		RunActive  = 2'd1,
		RunDone    = 2'd2
	} run_state_t;

endpackage

/* src/run_control.sv */
// Run-phase controller
// Tracks load, run and done phases of the processor and keeps
// the most recent status report for the display

`timescale 1ns/1ns

module run_control
(
	input  logic                       i_Clk,
	input  logic                       Internal_Reset_n,
	input  logic                       i_LoadDone,      // Image load finished
	input  logic                       i_StatusStrobe,  // One status report
	input  monitor_pkg::status_code_t  i_StatusCode,
	input  monitor_pkg::status_value_t i_StatusValue,
	output logic                       o_Counting,      // High only while running
	output monitor_pkg::status_code_t  o_LastCode,
	output monitor_pkg::status_value_t o_LastValue,
	output logic                       o_DoneLed,
	output logic                       o_RunLed
);

	import monitor_pkg::*;

	run_state_t State;      // Registered phase
	run_state_t StateNext;
	logic       ReportValid;   // Strobe carrying a real code

	assign ReportValid = i_StatusStrobe && (i_StatusCode != StatusNoop);

	// ====================
	// Next-phase logic
	// ====================
	always_comb
	begin
		StateNext = State;
		case (State)
			RunLoading : if (i_LoadDone) StateNext = RunActive;
			RunActive  : if (ReportValid && (i_StatusCode == StatusDone)) StateNext = RunDone;
			default    : StateNext = State;   // Done holds until reset
		endcase
	end

	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			State       <= RunLoading;
			o_LastCode  <= StatusNoop;
			o_LastValue <= '0;
		end
		else
		begin
			State <= StateNext;
			// Reports are kept in any phase
			if (ReportValid)
			begin
				o_LastCode  <= i_StatusCode;
				o_LastValue <= i_StatusValue;
			end
		end
	end

	// Outputs decode the registered phase directly
	assign o_Counting = (State == RunActive);
	assign o_DoneLed  = (State == RunDone);
	assign o_RunLed   = (State != RunDone);   // Lit until the program ends

	// Done phase is sticky until the next reset
	DoneSticky : assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		(State == RunDone) |=> (State == RunDone))
		else $error("run_control left RunDone without reset");

endmodule

/* src/perf_counters.sv */
// Performance counters
// Counts run cycles and retired instructions while the
// processor is in its active phase, both wrap at 32 bits

`timescale 1ns/1ns

module perf_counters
(
	input  logic                i_Clk,
	input  logic                Internal_Reset_n,
	input  logic                i_Counting,       // Registered run phase
	input  logic                i_RetireStrobe,   // One instruction retired
	output monitor_pkg::count_t o_CycleCount,
	output monitor_pkg::count_t o_InstrCount
);

	import monitor_pkg::*;

	count_t CycleNext;
	count_t InstrNext;

	// ====================
	// Increment logic
	// ====================
	// Plain adds, rollover is allowed
	always_comb
	begin
		CycleNext = o_CycleCount;
		InstrNext = o_InstrCount;
		if (i_Counting)
		begin
			CycleNext = o_CycleCount + count_t'(1);   // Every active cycle
			if (i_RetireStrobe)
				InstrNext = o_InstrCount + count_t'(1);
		end
	end

	// ====================
	// Counter registers
	// ====================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			o_CycleCount <= '0;
			o_InstrCount <= '0;
		end
		else
		begin
			o_CycleCount <= CycleNext;
			o_InstrCount <= InstrNext;
		end
	end

	// Frozen outside the active phase, including after DONE
	CountFrozen : assert property (@(posedge i_Clk) disable iff (!Internal_Reset_n)
		!i_Counting |=> ($stable(o_CycleCount) && $stable(o_InstrCount)))
		else $error("perf_counters moved while counting was off");

endmodule

/* src/display_select.sv */
// Display source selection
// Picks eight hex digits from the counters or the status view
// according to the switch setting, one register stage

`timescale 1ns/1ns

module display_select
(
	input  logic                             i_Clk,
	input  logic                             Internal_Reset_n,
	input  monitor_pkg::display_mode_t       i_DisplayMode,   // Switch setting
	input  monitor_pkg::count_t              i_CycleCount,
	input  monitor_pkg::count_t              i_InstrCount,
	input  monitor_pkg::status_value_t       i_LastValue,     // Latest report payload
	input  monitor_pkg::fetch_addr_t         i_FetchAddr,
	output monitor_pkg::nibble_t [7:0]       o_Nibbles        // Digit 0 lowest
);

	import monitor_pkg::*;

	nibble_t [7:0] NibblesNext;

	// ====================
	// Source mux
	// ====================
	always_comb
	begin
		NibblesNext = '0;   // Unused digits read zero
		case (i_DisplayMode)
			ModeStatus :
			begin
				// Value low byte on the right
				NibblesNext[0] = i_LastValue[3:0];
				NibblesNext[1] = i_LastValue[7:4];
				// Fetch address low byte on the left
				NibblesNext[6] = i_FetchAddr[3:0];
				NibblesNext[7] = i_FetchAddr[7:4];
			end

			ModeCycles :
			begin
				for (int i = 0; i < 8; i++)
					NibblesNext[i] = i_CycleCount[4*i +: 4];
			end

			ModeInstrs :
			begin
				for (int i = 0; i < 8; i++)
					NibblesNext[i] = i_InstrCount[4*i +: 4];
			end

			default :
			begin
				NibblesNext = '0;   // Blank mode, zeros everywhere
			end
		endcase
	end

	// ====================
	// Digit register
	// ====================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			o_Nibbles <= '0;
		end
		else
		begin
			o_Nibbles <= NibblesNext;   // One edge behind the sources
		end
	end

endmodule

/* src/segment_encoder.sv */
// Seven-segment encoder for the eight board digits
// Registered hex decode, active low, with the pass/fail/done
// glyph replacing digit 2 in the status view

`timescale 1ns/1ns

module segment_encoder
(
	input  logic                       i_Clk,
	input  logic                       Internal_Reset_n,
	input  monitor_pkg::nibble_t [7:0] i_Nibbles,
	input  monitor_pkg::display_mode_t i_DisplayMode,
	input  monitor_pkg::status_code_t  i_LastCode,
	output monitor_pkg::segments_t     o_Hex0,
	output monitor_pkg::segments_t     o_Hex1,
	output monitor_pkg::segments_t     o_Hex2,
	output monitor_pkg::segments_t     o_Hex3,
	output monitor_pkg::segments_t     o_Hex4,
	output monitor_pkg::segments_t     o_Hex5,
	output monitor_pkg::segments_t     o_Hex6,
	output monitor_pkg::segments_t     o_Hex7
);

	import monitor_pkg::*;

	// Standard hex font, bit order g..a, 0 lights a segment
	function automatic segments_t HexToSegments(input nibble_t Digit);
		segments_t Seg;
		case (Digit)
			4'h0 : Seg = 7'b1000000;
			4'h1 : Seg = 7'b1111001;
			4'h2 : Seg = 7'b0100100;
			4'h3 : Seg = 7'b0110000;
			4'h4 : Seg = 7'b0011001;
			4'h5 : Seg = 7'b0010010;
			4'h6 : Seg = 7'b0000010;
			4'h7 : Seg = 7'b1111000;
			4'h8 : Seg = 7'b0000000;
			4'h9 : Seg = 7'b0010000;
			4'hA : Seg = 7'b0001000;
			4'hB : Seg = 7'b0000011;   // Lower case b
			4'hC : Seg = 7'b1000110;
			4'hD : Seg = 7'b0100001;   // Lower case d
			4'hE : Seg = 7'b0000110;
			default : Seg = 7'b0001110;
		endcase
		return Seg;
	endfunction

	// Status glyph, P / F / d, blank when no report yet
	function automatic segments_t CodeToGlyph(input status_code_t Code);
		segments_t Seg;
		case (Code)
			StatusPass : Seg = 7'b0001100;
			StatusFail : Seg = 7'b0001110;
			StatusDone : Seg = 7'b0100001;
			default    : Seg = 7'b1111111;
		endcase
		return Seg;
	endfunction

	display_mode_t   ModeDly;    // Mode aligned with the nibble register
	status_code_t    CodeDly;    // Code aligned the same way
	segments_t [7:0] SegReg;

	// ====================
	// Alignment and decode
	// ====================
	always_ff @(posedge i_Clk or negedge Internal_Reset_n)
	begin
		if (!Internal_Reset_n)
		begin
			ModeDly <= ModeStatus;
			CodeDly <= StatusNoop;
			SegReg  <= {8{7'b1111111}};   // All digits dark
		end
		else
		begin
			ModeDly <= i_DisplayMode;
			CodeDly <= i_LastCode;
			for (int i = 0; i < 8; i++)
				SegReg[i] <= HexToSegments(i_Nibbles[i]);
			if (ModeDly == ModeStatus)
				SegReg[2] <= CodeToGlyph(CodeDly);   // Glyph overrides digit 2
		end
	end

	assign o_Hex0 = SegReg[0];
	assign o_Hex1 = SegReg[1];
	assign o_Hex2 = SegReg[2];
	assign o_Hex3 = SegReg[3];
	assign o_Hex4 = SegReg[4];
	assign o_Hex5 = SegReg[5];
	assign o_Hex6 = SegReg[6];
	assign o_Hex7 = SegReg[7];

endmodule

/* src/board_monitor.sv */
// Board-level processor monitor
// Run control, performance counters and the eight-digit display
// path around the processor status and retire signals

`timescale 1ns/1ns

module board_monitor
(
	input  logic                       i_Clk,
	input  logic                       Internal_Reset_n,
	input  logic                       i_LoadDone,       // From the image loader
	input  logic                       i_RetireStrobe,   // From write-back
	input  logic                       i_StatusStrobe,   // Status report valid
	input  monitor_pkg::status_code_t  i_StatusCode,
	input  monitor_pkg::status_value_t i_StatusValue,
	input  monitor_pkg::fetch_addr_t   i_FetchAddr,
	input  monitor_pkg::display_mode_t i_DisplayMode,    // Switches
	output monitor_pkg::segments_t     o_Hex0,
	output monitor_pkg::segments_t     o_Hex1,
	output monitor_pkg::segments_t     o_Hex2,
	output monitor_pkg::segments_t     o_Hex3,
	output monitor_pkg::segments_t     o_Hex4,
	output monitor_pkg::segments_t     o_Hex5,
	output monitor_pkg::segments_t     o_Hex6,
	output monitor_pkg::segments_t     o_Hex7,
	output logic                       o_DoneLed,
	output logic                       o_RunLed
);

	import monitor_pkg::*;

	// ====================
	// Internal wiring
	// ====================
	logic          Counting;     // Active phase
	status_code_t  LastCode;
	status_value_t LastValue;
	count_t        CycleCount;
	count_t        InstrCount;
	nibble_t [7:0] Nibbles;      // Selected digits

	run_control u_RunControl (.i_Clk(i_Clk), .Internal_Reset_n(Internal_Reset_n),
		.i_LoadDone(i_LoadDone), .i_StatusStrobe(i_StatusStrobe), .i_StatusCode(i_StatusCode),
		.i_StatusValue(i_StatusValue), .o_Counting(Counting), .o_LastCode(LastCode),
		.o_LastValue(LastValue), .o_DoneLed(o_DoneLed), .o_RunLed(o_RunLed));

	perf_counters u_PerfCounters (.i_Clk(i_Clk), .Internal_Reset_n(Internal_Reset_n),
		.i_Counting(Counting), .i_RetireStrobe(i_RetireStrobe),
		.o_CycleCount(CycleCount), .o_InstrCount(InstrCount));

	display_select u_DisplaySelect (.i_Clk(i_Clk), .Internal_Reset_n(Internal_Reset_n),
		.i_DisplayMode(i_DisplayMode), .i_CycleCount(CycleCount), .i_InstrCount(InstrCount),
		.i_LastValue(LastValue), .i_FetchAddr(i_FetchAddr), .o_Nibbles(Nibbles));

	segment_encoder u_SegmentEncoder (.i_Clk(i_Clk), .Internal_Reset_n(Internal_Reset_n),
		.i_Nibbles(Nibbles), .i_DisplayMode(i_DisplayMode), .i_LastCode(LastCode),
		.o_Hex0(o_Hex0), .o_Hex1(o_Hex1), .o_Hex2(o_Hex2), .o_Hex3(o_Hex3),
		.o_Hex4(o_Hex4), .o_Hex5(o_Hex5), .o_Hex6(o_Hex6), .o_Hex7(o_Hex7));

endmodule

/* bench/tb_clock.sv */
// Bench clock source
// Free-running 8 ns clock for the monitor bench

`timescale 1ns/1ns

module tb_clock
(
	output logic o_Clk
);

	initial
	begin
		o_Clk = 1'b0;
		forever #4 o_Clk = ~o_Clk;   // 8 ns period
	end

endmodule

/* bench/tb_board_monitor.sv */
// Board monitor bench
// Reads command lines from the patterns file, drives the monitor and
// checks digits, LEDs and counts against a small reference model

`timescale 1ns/1ns

module tb_board_monitor;

	import monitor_pkg::*;

	localparam int DoneTimeout = 16;   // Cycles allowed for the done LED
	// Hex font 0..F in g..a order, lit on 0
	localparam segments_t FontTable [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12,
		7'h02, 7'h78, 7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e};

	logic            Clk;
	logic            Internal_Reset_n;
	logic            LoadDone;
	logic            RetireStrobe;
	logic            StatusStrobe;
	status_code_t    StatusCode;
	status_value_t   StatusValue;
	fetch_addr_t     FetchAddr;
	display_mode_t   DisplayMode;
	segments_t [7:0] Digits;          // o_Hex7..o_Hex0
	logic            DoneLed;
	logic            RunLed;

	// ====================
	// Reference model
	// ====================
	run_state_t    ModelState;
	count_t        CycleHist [3];     // Index k is the value k edges ago
	count_t        InstrHist [3];
	status_value_t ValueHist [3];
	fetch_addr_t   FetchHist [2];     // Fetch input as sampled
	integer        Seed;
	int            ValueErrors;
	int            TimeoutErrors;
	int            OtherErrors;
	logic          AbortRun;

	tb_clock u_Clock (.o_Clk(Clk));

	board_monitor i_dut (.i_Clk(Clk), .Internal_Reset_n(Internal_Reset_n),
		.i_LoadDone(LoadDone), .i_RetireStrobe(RetireStrobe), .i_StatusStrobe(StatusStrobe),
		.i_StatusCode(StatusCode), .i_StatusValue(StatusValue), .i_FetchAddr(FetchAddr),
		.i_DisplayMode(DisplayMode), .o_Hex0(Digits[0]), .o_Hex1(Digits[1]),
		.o_Hex2(Digits[2]), .o_Hex3(Digits[3]), .o_Hex4(Digits[4]), .o_Hex5(Digits[5]),
		.o_Hex6(Digits[6]), .o_Hex7(Digits[7]), .o_DoneLed(DoneLed), .o_RunLed(RunLed));

	// One edge of the run rules on the inputs the DUT sampled
	task automatic ModelEdge();
		count_t        Cycles;
		count_t        Instrs;
		status_value_t Value;
		Cycles = CycleHist[0];
		Instrs = InstrHist[0];
		Value  = ValueHist[0];
		if (ModelState == RunActive)   // Old phase gates counting
		begin
			Cycles = Cycles + count_t'(1);
			if (RetireStrobe)
				Instrs = Instrs + count_t'(1);
		end
		if (StatusStrobe && (StatusCode != StatusNoop))
			Value = StatusValue;            // Kept in every phase
		if ((ModelState == RunLoading) && LoadDone)
			ModelState = RunActive;
		else if ((ModelState == RunActive) && StatusStrobe && (StatusCode == StatusDone))
			ModelState = RunDone;
		for (int k = 2; k > 0; k--)
		begin
			CycleHist[k] = CycleHist[k - 1];
			InstrHist[k] = InstrHist[k - 1];
			ValueHist[k] = ValueHist[k - 1];
		end
		CycleHist[0] = Cycles;
		InstrHist[0] = Instrs;
		ValueHist[0] = Value;
		FetchHist[1] = FetchHist[0];
		FetchHist[0] = FetchAddr;
	endtask

	// Edge, model update, then the drive point 1 ns later
	task automatic StepClock();
		@(posedge Clk);
		ModelEdge();
		#1;
	endtask

	// ====================
	// Compare tasks
	// ====================
	task automatic CheckSegments(input string Name, input segments_t Got, input segments_t Exp);
		if (Got !== Exp)
		begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, Name, Got, Exp);
			ValueErrors++;
		end
	endtask

	task automatic CheckLeds(input string Name, input logic [1:0] Got, input logic [1:0] Exp);
		if (Got !== Exp)
		begin
			$display("** Error at %0t ns: %s is %b, expected %b", $time, Name, Got, Exp);
			ValueErrors++;
		end
	endtask

	task automatic CheckCount(input string Name, input count_t Got, input count_t Exp);
		if (Got !== Exp)
		begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, Name, Got, Exp);
			ValueErrors++;
		end
	endtask

	// Turn the eight digits back into a number
	task automatic ReadDisplayedCount(output count_t Value, output logic Valid);
		logic Found;
		Value = '0;
		Valid = 1'b1;
		for (int d = 0; d < 8; d++)
		begin
			Found = 1'b0;
			for (int n = 0; n < 16; n++)
			begin
				if (!Found && (Digits[d] === FontTable[n]))
				begin
					Value[4*d +: 4] = 4'(n);
					Found = 1'b1;
				end
			end
			if (!Found)
				Valid = 1'b0;
		end
	endtask

	task automatic CheckCountView();
		count_t Shown;
		logic   Valid;
		ReadDisplayedCount(Shown, Valid);
		if (!Valid)
		begin
			$display("At %0t ns a digit shows a pattern that is not a hex digit", $time);
			OtherErrors++;
		end
		else if (DisplayMode == ModeCycles)
			CheckCount("o_Hex7..o_Hex0 cycle count", Shown, CycleHist[2]);
		else if (DisplayMode == ModeInstrs)
			CheckCount("o_Hex7..o_Hex0 instruction count", Shown, InstrHist[2]);
		else
		begin
			$display("Count check asked for while the display is not in a counter mode");
			OtherErrors++;
		end
	endtask

	// Value on the right and fetch address on the left with zeros between
	task automatic CheckStatusView();
		CheckSegments("o_Hex0", Digits[0], FontTable[ValueHist[2][3:0]]);
		CheckSegments("o_Hex1", Digits[1], FontTable[ValueHist[2][7:4]]);
		for (int d = 3; d < 6; d++)
			CheckSegments($sformatf("o_Hex%0d", d), Digits[d], FontTable[0]);
		CheckSegments("o_Hex6", Digits[6], FontTable[FetchHist[1][3:0]]);
		CheckSegments("o_Hex7", Digits[7], FontTable[FetchHist[1][7:4]]);
	endtask

	task automatic WaitForDoneLed();
		int Cycles;
		Cycles = 0;
		while ((DoneLed !== 1'b1) && (Cycles < DoneTimeout))
		begin
			StepClock();
			Cycles++;
		end
		if (DoneLed !== 1'b1)
		begin
			$display("Timeout: the done LED did not rise within %0d cycles", DoneTimeout);
			TimeoutErrors++;
			AbortRun = 1'b1;
		end
	endtask

	// ====================
	// Stimulus
	// ====================
	task automatic SendRetires(input logic [31:0] Count);
		logic [31:0] RandWord;
		repeat (Count)
		begin
			RandWord = $random(Seed);
			repeat (RandWord[1:0]) StepClock();   // Gap of 0 to 3 idle cycles
			RetireStrobe = 1'b1;
			StepClock();
			RetireStrobe = 1'b0;
		end
	endtask

	task automatic SendStatus(input status_code_t Code, input status_value_t Value);
		StatusStrobe = 1'b1;
		StatusCode   = Code;
		StatusValue  = Value;
		StepClock();
		StatusStrobe = 1'b0;
	endtask

	task automatic RunCommand(input string Line);
		byte         Cmd;
		logic [31:0] ArgA;
		logic [31:0] ArgB;
		Cmd  = Line.getc(0);
		ArgA = '0;
		ArgB = '0;
		void'($sscanf(Line.substr(1, Line.len() - 1), "%h %h", ArgA, ArgB));
		case (Cmd)
			"I" : repeat (ArgA) StepClock();
			"L" : LoadDone = 1'b1;
			"R" : SendRetires(ArgA);
			"S" : SendStatus(ArgA[1:0], ArgB[15:0]);
			"A" : FetchAddr = ArgA[21:0];
			"M" :
			begin
				DisplayMode = ArgA[1:0];
				repeat (2) StepClock();   // Mode reaches the segments after 2 edges
			end
			"B" :
			begin
				for (int d = 0; d < 8; d++)
					CheckSegments($sformatf("o_Hex%0d", d), Digits[d], ArgA[6:0]);
			end
			"D" : CheckSegments($sformatf("o_Hex%0d", ArgA[2:0]), Digits[ArgA[2:0]], ArgB[6:0]);
			"N" : CheckCountView();
			"V" : CheckStatusView();
			"E" : CheckLeds("o_DoneLed,o_RunLed", {DoneLed, RunLed},
				{ModelState == RunDone, ModelState != RunDone});
			"W" : WaitForDoneLed();
			default :
			begin
				$display("Unknown command in the patterns file: %s", Line);
				OtherErrors++;
			end
		endcase
	endtask

	initial
	begin
		int    Fd;
		int    Got;
		string Line;
		Seed = 32'h67cea7dd;
		{ValueErrors, TimeoutErrors, OtherErrors} = '0;
		AbortRun = 1'b0;
		Internal_Reset_n = 1'b0;
		{LoadDone, RetireStrobe, StatusStrobe} = 3'b000;
		StatusCode  = StatusNoop;
		StatusValue = '0;
		FetchAddr   = '0;
		DisplayMode = ModeStatus;
		ModelState  = RunLoading;   // Model starts in the reset state
		CycleHist   = '{default: '0};
		InstrHist   = '{default: '0};
		ValueHist   = '{default: '0};
		FetchHist   = '{default: '0};
		repeat (4) @(posedge Clk);
		#1;
		Internal_Reset_n = 1'b1;
		Fd = $fopen("bench/monitor_patterns.txt", "r");
		if (Fd == 0)
		begin
			$display("Could not open the patterns file bench/monitor_patterns.txt");
			OtherErrors++;
		end
		else
		begin
			while (!AbortRun && !$feof(Fd))
			begin
				Got = $fgets(Line, Fd);
				if ((Got > 1) && (Line.getc(0) != "#"))
					RunCommand(Line);
			end
			$fclose(Fd);
		end
		$display("Errors: %0d value, %0d timeout, %0d other",
			ValueErrors, TimeoutErrors, OtherErrors);
		if ((ValueErrors + TimeoutErrors + OtherErrors) == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* bench/monitor_patterns.txt */
# Columns: command letter, then up to two hex arguments
# I n idle, L load-done, R k retires, S code value, A fetch addr, M mode
# B seg all digits, D idx seg one digit, N count, V status view, E LEDs, W wait done
B 7f
E
M 1
I 6
N
B 40
L
I 5
R 8
I 3
N
M 2
N
R 5
I 2
N
M 1
N
A 2a5c7
S 1 00a5
I 2
M 0
V
D 2 0c
S 2 013c
I 3
V
D 2 0e
S 0 1234
I 3
V
D 2 0e
E
S 3 00d0
W
E
I 2
D 2 21
V
R 6
I 4
M 1
N
M 2
N
M 3
B 40
E

/* filelist.f */
src/monitor_pkg.sv
src/run_control.sv
src/perf_counters.sv
src/display_select.sv
src/segment_encoder.sv
src/board_monitor.sv
bench/tb_clock.sv
bench/tb_board_monitor.sv

/* run.sh */
#!/bin/sh
# Build the board monitor bench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_board_monitor -f filelist.f \
	-Mdir obj_dir -o sim_board_monitor

./obj_dir/sim_board_monitor | tee sim.log

# Pass only if the bench printed its pass line
grep -qx "Test OK" sim.log
